//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/decoder.sv
      - hdl/reg_file.sv
      - hdl/execute_unit.sv
      - hdl/hazard_unit.sv
      - hdl/mem_unit.sv
      - hdl/rv_core.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/tb_rv_core.sv

//--- hdl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path width
`define CORE_XLEN 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import isa_pkg::*, pipe_pkg::*; (
    input  if_id_t    if_id,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output id_ex_t    dec
);

    word_t instr;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    logic [2:0] funct3;
    logic uses_rs1;
    logic uses_rs2;
    logic valid;

    assign instr = if_id.instr;
    assign funct3 = instr[14:12];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec = '0;
        dec.pc = if_id.pc;
        dec.rd = instr[11:7];
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        valid = 1'b1;
        case (opcode_t'(instr[6:0]))
            OP: begin
                uses_rs2 = 1'b1;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010: dec.alu_op = ALU_SLT;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b111: dec.alu_op = ALU_AND;
                    default: valid = 1'b0;
                endcase
            end
            OP_IMM: begin
                // ADDI only
                dec.imm = imm_i;
                dec.use_imm = 1'b1;
                dec.reg_write = 1'b1;
                valid = (funct3 == 3'b000);
            end
            LUI: begin
                uses_rs1 = 1'b0;
                dec.imm = imm_u;
                dec.use_imm = 1'b1;
                dec.alu_op = ALU_PASS_B;
                dec.reg_write = 1'b1;
            end
            LOAD: begin
                dec.imm = imm_i;
                dec.use_imm = 1'b1;
                dec.is_load = 1'b1;
                dec.reg_write = 1'b1;
            end
            STORE: begin
                uses_rs2 = 1'b1;
                dec.imm = imm_s;
                dec.use_imm = 1'b1;
                dec.is_store = 1'b1;
            end
            BRANCH: begin
                uses_rs2 = 1'b1;
                dec.imm = imm_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                valid = (funct3[2:1] == 2'b00);
            end
            JAL: begin
                uses_rs1 = 1'b0;
                dec.imm = imm_j;
                dec.is_jal = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: valid = 1'b0;
        endcase

        // Unsupported encodings become a bubble
        if (!valid) begin
            dec = '0;
            dec.pc = if_id.pc;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
        end
        if (dec.rd == '0) begin
            dec.reg_write = 1'b0;
        end

        // Unused sources read as x0 so they never trigger a hazard
        rs1 = uses_rs1 ? instr[19:15] : '0;
        rs2 = uses_rs2 ? instr[24:20] : '0;
        dec.rs1 = rs1;
        dec.rs2 = rs2;
    end

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     interlock,
    input  logic     flush,
    input  logic     stall,
    input  id_ex_t   dec,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    ex_mem_value,
    input  word_t    mem_wb_value,
    output ex_mem_t  ex_out,
    output logic     branch_taken,
    output word_t    branch_target,
    output id_ex_t   id_ex
);

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_res;
    word_t pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else if (!interlock) begin
            if (stall || flush) begin
                id_ex <= '0;
            end else begin
                id_ex <= dec;
            end
        end
    end

    // Operand forwarding
    always_comb begin
        case (fwd_a)
            FWD_EX_MEM: op_a = ex_mem_value;
            FWD_MEM_WB: op_a = mem_wb_value;
            default:    op_a = id_ex.rs1_val;
        endcase
        case (fwd_b)
            FWD_EX_MEM: op_b = ex_mem_value;
            FWD_MEM_WB: op_b = mem_wb_value;
            default:    op_b = id_ex.rs2_val;
        endcase
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_res = op_a - alu_b;
            ALU_AND:    alu_res = op_a & alu_b;
            ALU_OR:     alu_res = op_a | alu_b;
            ALU_XOR:    alu_res = op_a ^ alu_b;
            ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(alu_b));
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = op_a + alu_b;
        endcase
    end

    assign pc_plus4 = id_ex.pc + word_t'(4);
    assign branch_target = id_ex.pc + id_ex.imm;
    // BNE inverts the equality test
    assign branch_taken = id_ex.is_jal
        || (id_ex.is_branch && ((op_a == op_b) != id_ex.branch_ne));

    always_comb begin
        ex_out.result = id_ex.is_jal ? pc_plus4 : alu_res;
        ex_out.store_data = op_b;
        ex_out.rd = id_ex.rd;
        ex_out.is_load = id_ex.is_load;
        ex_out.is_store = id_ex.is_store;
        ex_out.reg_write = id_ex.reg_write;
    end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module fetch_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   flush,
    input  logic   interlock,
    input  word_t  branch_target,
    input  word_t  imem_data,
    output word_t  pc,
    output if_id_t if_id
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `CORE_RESET_PC;
            if_id.pc <= `CORE_RESET_PC;
            if_id.instr <= `CORE_NOP;
        end else if (!interlock) begin
            if (flush) begin
                // Redirect and squash the slot being fetched
                pc <= branch_target;
                if_id.instr <= `CORE_NOP;
            end else if (!stall) begin
                pc <= pc + word_t'(4);
                if_id.pc <= pc;
                if_id.instr <= imem_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  id_ex_t    id_ex,
    input  ex_mem_t   ex_mem,
    input  mem_wb_t   mem_wb,
    input  logic      branch_taken,
    input  logic      imem_ack_n,
    input  logic      dmem_ack_n,
    output fwd_sel_t  fwd_a,
    output fwd_sel_t  fwd_b,
    output logic      stall,
    output logic      flush,
    output logic      interlock
);

    logic dmem_pending;

    // Newest producer wins; a load in MEM has no data yet
    function automatic fwd_sel_t pick_source(input reg_addr_t src, input ex_mem_t mem_stage,
                                             input mem_wb_t wb_stage);
        if (src != '0 && mem_stage.reg_write && !mem_stage.is_load && mem_stage.rd == src) begin
            return FWD_EX_MEM;
        end
        if (src != '0 && wb_stage.reg_write && wb_stage.rd == src) begin
            return FWD_MEM_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = pick_source(id_ex.rs1, ex_mem, mem_wb);
        fwd_b = pick_source(id_ex.rs2, ex_mem, mem_wb);
    end

    // Load in EX feeding the instruction in decode
    assign stall = id_ex.is_load && id_ex.reg_write
        && (id_ex.rd == rs1 || id_ex.rd == rs2);

    assign flush = branch_taken;

    assign dmem_pending = (ex_mem.is_load || ex_mem.is_store) && dmem_ack_n;
    assign interlock = imem_ack_n || dmem_pending;

endmodule

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

`include "core_consts.svh"

package isa_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

endpackage

`default_nettype wire

//--- hdl/mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    interlock,
    input  ex_mem_t ex_in,
    input  word_t   dmem_rdata,
    output word_t   dmem_addr,
    output word_t   dmem_wdata,
    output logic    dmem_req,
    output logic    dmem_write,
    output ex_mem_t ex_mem,
    output mem_wb_t wb
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (!interlock) begin
            ex_mem <= ex_in;
        end
    end

    // Data bus straight from EX/MEM
    assign dmem_addr = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_req = ex_mem.is_load || ex_mem.is_store;
    assign dmem_write = ex_mem.is_store;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else if (!interlock) begin
            wb.value <= ex_mem.is_load ? dmem_rdata : ex_mem.result;
            wb.rd <= ex_mem.rd;
            wb.reg_write <= ex_mem.reg_write;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      reg_write;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      is_load;
        logic      is_store;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t     value;
        reg_addr_t rd;
        logic      reg_write;
    } mem_wb_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  mem_wb_t   wb,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Write-through so decode sees a value being written back this cycle
    always_comb begin
        if (rs1 == '0) begin
            rdata1 = '0;
        end else if (wb.reg_write && wb.rd == rs1) begin
            rdata1 = wb.value;
        end else begin
            rdata1 = regs[rs1];
        end

        if (rs2 == '0) begin
            rdata2 = '0;
        end else if (wb.reg_write && wb.rd == rs2) begin
            rdata2 = wb.value;
        end else begin
            rdata2 = regs[rs2];
        end
    end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import isa_pkg::*, pipe_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // Instruction bus
    output word_t imem_addr,
    input  word_t imem_data,
    input  logic  imem_ack_n,

    // Data bus
    output word_t dmem_addr,
    output word_t dmem_wdata,
    input  word_t dmem_rdata,
    output logic  dmem_req,
    output logic  dmem_write,
    input  logic  dmem_ack_n
);

    if_id_t    if_id;
    reg_addr_t rs1;
    reg_addr_t rs2;
    id_ex_t    dec_ctrl;
    id_ex_t    dec;
    word_t     rdata1;
    word_t     rdata2;
    id_ex_t    id_ex;
    ex_mem_t   ex_out;
    ex_mem_t   ex_mem;
    mem_wb_t   wb;
    word_t     branch_target;
    logic      branch_taken;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    logic      stall;
    logic      flush;
    logic      interlock;

    fetch_unit fetch_unit_inst (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .flush(flush),
        .interlock(interlock),
        .branch_target(branch_target),
        .imem_data(imem_data),
        .pc(imem_addr),
        .if_id(if_id)
    );

    decoder decoder_inst (
        .if_id(if_id),
        .rs1(rs1),
        .rs2(rs2),
        .dec(dec_ctrl)
    );

    reg_file reg_file_inst (
        .clk(clk),
        .rst(rst),
        .rs1(rs1),
        .rs2(rs2),
        .wb(wb),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    // Register operands join the decoded controls
    always_comb begin
        dec = dec_ctrl;
        dec.rs1_val = rdata1;
        dec.rs2_val = rdata2;
    end

    execute_unit execute_unit_inst (
        .clk(clk),
        .rst(rst),
        .interlock(interlock),
        .flush(flush),
        .stall(stall),
        .dec(dec),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .ex_mem_value(ex_mem.result),
        .mem_wb_value(wb.value),
        .ex_out(ex_out),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .id_ex(id_ex)
    );

    mem_unit mem_unit_inst (
        .clk(clk),
        .rst(rst),
        .interlock(interlock),
        .ex_in(ex_out),
        .dmem_rdata(dmem_rdata),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_req(dmem_req),
        .dmem_write(dmem_write),
        .ex_mem(ex_mem),
        .wb(wb)
    );

    hazard_unit hazard_unit_inst (
        .rs1(rs1),
        .rs2(rs2),
        .id_ex(id_ex),
        .ex_mem(ex_mem),
        .mem_wb(wb),
        .branch_taken(branch_taken),
        .imem_ack_n(imem_ack_n),
        .dmem_ack_n(dmem_ack_n),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .stall(stall),
        .flush(flush),
        .interlock(interlock)
    );

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/hazard_unit.sv
hdl/mem_unit.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

//--- testbench/core_input.txt
# P <word> is one program word from address 0 upward, S <addr> <data> one expected store
# E ends a test; the last program word of each test is the JAL x0,0 halt loop
P 00500093 P 00708113 P 002081b3 P 40208233 P 123452b7 P 0032c333
P 001223b3 P 00236433 P 00908013 P 10302023 P 10402223 P 10502423
P 10602623 P 10702823 P 10802a23 P 10002c23 P 0000006f
S 00000100 00000011 S 00000104 fffffff9 S 00000108 12345000
S 0000010c 12345011 S 00000110 00000001 S 00000114 1234501d
S 00000118 00000000
E
# Load-use with data memory fill addr ^ a5a50000
P 04002083 P 00108133 P 20202023 P 20002183 P 20302223 P 0000006f
S 00000200 4b4a0080
S 00000204 4b4a0080
E
# Taken BEQ, taken BNE, JAL x5 and a BEQ that falls through
P 00300093 P 00300113 P 00208663 P 30102023 P 30102223 P 00009663
P 30202423 P 30202623 P 00c002ef P 30102023 P 30102023 P 00008463
P 30502823 P 0000006f
S 00000310 00000024
E

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module tb_rv_core import isa_pkg::*; ();

    logic  clk;
    logic  rst;
    word_t imem_addr;
    word_t imem_data;
    logic  imem_ack_n;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_req;
    logic  dmem_write;
    logic  dmem_ack_n;

    word_t imem [0:255];
    word_t dmem [0:1023];
    word_t prog_q [$];
    word_t st_addr_q [$];
    word_t st_data_q [$];
    int    prog_len [$];
    int    st_len [$];
    int    seed = 32'h0e0a_3d94;
    int    errors = 0;
    int    failed_runs = 0;
    int    limit_cycles = 0;
    logic  wait_states = 1'b0;
    logic  running = 1'b0;
    int    exp_base;
    int    exp_len;
    int    store_idx;

    rv_core dut0 (
        .clk(clk), .rst(rst),
        .imem_addr(imem_addr), .imem_data(imem_data), .imem_ack_n(imem_ack_n),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .dmem_req(dmem_req), .dmem_write(dmem_write), .dmem_ack_n(dmem_ack_n)
    );

    assign imem_data = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Random wait states on both buses in the second pass
    always @(posedge clk) begin
        if (wait_states && !rst) begin
            imem_ack_n <= ($random(seed) & 3) == 0;
            dmem_ack_n <= ($random(seed) & 3) == 0;
        end else begin
            imem_ack_n <= 1'b0;
            dmem_ack_n <= 1'b0;
        end
    end

    // An access only retires when the whole pipeline moves
    always @(posedge clk) begin
        if (running && !rst && dmem_req && dmem_write && !dmem_ack_n && !imem_ack_n) begin
            if (store_idx >= exp_len) begin
                $display("Unexpected extra store to %h at %0t", dmem_addr, $time);
                errors++;
            end else begin
                check_word("dmem_addr", dmem_addr, st_addr_q[exp_base + store_idx]);
                check_word("dmem_wdata", dmem_wdata, st_data_q[exp_base + store_idx]);
            end
            dmem[dmem_addr[11:2]] = dmem_wdata;
            store_idx++;
        end
    end

    task automatic read_tests();
        int    fd;
        int    code;
        string tok;
        string line;
        word_t a;
        word_t d;
        int    np;
        int    ns;
        fd = $fopen("testbench/core_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/core_input.txt");
        end else begin
            np = 0;
            ns = 0;
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(line, fd);
                end else if (tok == "P") begin
                    code = $fscanf(fd, "%h", a);
                    prog_q.push_back(a);
                    np++;
                end else if (tok == "S") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    st_addr_q.push_back(a);
                    st_data_q.push_back(d);
                    ns++;
                end else if (tok == "E") begin
                    prog_len.push_back(np);
                    st_len.push_back(ns);
                    np = 0;
                    ns = 0;
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t, input int pbase, input int sbase, input logic rnd);
        int    hits;
        int    err0;
        word_t halt_pc;
        err0 = errors;
        halt_pc = word_t'((prog_len[t] - 1) * 4);
        @(posedge clk);
        rst <= 1'b1;
        wait_states <= rnd;
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'h00};
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i] = prog_q[pbase + i];
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = {i[29:0], 2'b00} ^ 32'ha5a5_0000;
        end
        exp_base = sbase;
        exp_len = st_len[t];
        store_idx = 0;
        running = 1'b1;
        repeat (16) @(posedge clk);
        check_word("imem_addr", imem_addr, `CORE_RESET_PC);
        check_bit("dmem_req", dmem_req, 1'b0);
        check_bit("dmem_write", dmem_write, 1'b0);
        rst <= 1'b0;
        // Done once the halt loop has been fetched a few times
        hits = 0;
        while (hits < 4) begin
            @(posedge clk);
            if (imem_addr == halt_pc && !imem_ack_n && !(dmem_req && dmem_ack_n)) begin
                hits++;
            end
        end
        running = 1'b0;
        if (store_idx < exp_len) begin
            $display("Test %0d missed %0d of its stores", t, exp_len - store_idx);
            errors++;
        end
        if (errors != err0) begin
            failed_runs++;
        end
        $display("test %0d %s: %s, %0d stores", t, rnd ? "random waits" : "no waits",
                 errors == err0 ? "ok" : "failed", store_idx);
    endtask

    initial begin
        int pbase;
        int sbase;
        int total;
        rst <= 1'b1;
        imem_ack_n <= 1'b0;
        dmem_ack_n <= 1'b0;
        read_tests();
        if (prog_len.size() == 0) begin
            $display("No tests were read from testbench/core_input.txt");
            errors++;
        end
        total = 0;
        foreach (prog_len[i]) begin
            total += prog_len[i];
        end
        limit_cycles = 2 * total * 40;
        for (int pass = 0; pass < 2; pass++) begin
            pbase = 0;
            sbase = 0;
            for (int t = 0; t < prog_len.size(); t++) begin
                run_test(t, pbase, sbase, pass == 1);
                pbase += prog_len[t];
                sbase += st_len[t];
            end
        end
        $display("runs %0d, failed %0d, errors %0d", 2 * prog_len.size(), failed_runs, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a test never finished", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
